//--- list.f
rtl/core_isa_pkg.sv
rtl/core_uarch_pkg.sv
rtl/core_decode.sv
rtl/core_execute.sv
rtl/core_result.sv
rtl/core_top.sv
tests/core_tb_clock.sv
tests/core_tb.sv

//--- rtl/core_decode.sv
`timescale 1ns/100ps
`default_nettype none

module core_decode
	import core_isa_pkg::*, core_uarch_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,

	input  logic         insn_valid,
	input  insn_word     insn,
	input  word          insn_pc,

	output reg_num       rn_addr,
	output reg_num       rm_addr,
	input  word          rn_rdata,
	input  word          rm_rdata,

	input  logic         wb_en,
	input  reg_num       wb_reg,
	input  word          wb_data,

	output logic         d_valid,
	output logic         d_undefined,
	output cond_code     d_cond,
	output dp_opcode     d_op,
	output logic         d_set_flags,
	output logic         d_is_imm,
	output imm8          d_imm,
	output rot4          d_rot,
	output shift_type    d_shift,
	output shift_amt     d_shamt,
	output reg_num       d_rd,
	output word          d_rn_val,
	output word          d_rm_val,
	output logic         d_branch,
	output logic         d_link,
	output branch_offset d_offset,
	output word          d_pc
);

	logic is_dp, is_branch, is_compare;
	logic mul_pattern, reg_shift, psr_xfer, dest_pc;
	logic undefined;
	word  rn_val, rm_val;

	function automatic word pick_operand(input reg_num addr, input word rdata, input word pc);
		if (addr == REG_PC)
			return pc + PC_AHEAD;
		else if (wb_en && wb_reg == addr)
			return wb_data; // Result of the instruction one ahead
		else
			return rdata;
	endfunction

	assign rn_addr = insn[19:16];
	assign rm_addr = insn[3:0];

	assign is_dp = insn[27:26] == 2'b00;
	assign is_branch = insn[27:25] == 3'b101;
	assign is_compare = insn[24:23] == 2'b10;

	// Bit 4 set with a register operand: multiply, extra transfers or shift by register
	assign mul_pattern = !insn[25] && insn[7] && insn[4];
	assign reg_shift = !insn[25] && !insn[7] && insn[4];
	assign psr_xfer = is_compare && !insn[20]; // Compare without S is MRS/MSR space
	assign dest_pc = insn[15:12] == REG_PC && !is_compare;

	assign undefined = !(is_branch || (is_dp && !mul_pattern && !reg_shift
		&& !psr_xfer && !dest_pc));

	assign rn_val = pick_operand(rn_addr, rn_rdata, insn_pc);
	assign rm_val = pick_operand(rm_addr, rm_rdata, insn_pc);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			d_valid <= 1'b0;
		else
			d_valid <= insn_valid;
	end

	always_ff @(posedge clk) begin
		if (insn_valid) begin
			d_undefined <= undefined;
			d_cond <= cond_code'(insn[31:28]);
			d_op <= dp_opcode'(insn[24:21]);
			d_set_flags <= insn[20];
			d_is_imm <= insn[25];
			d_imm <= insn[7:0];
			d_rot <= insn[11:8];
			d_shift <= shift_type'(insn[6:5]);
			d_shamt <= insn[11:7];
			d_rd <= insn[15:12];
			d_rn_val <= rn_val;
			d_rm_val <= rm_val;
			d_branch <= is_branch;
			d_link <= insn[24];
			d_offset <= insn[23:0];
			d_pc <= insn_pc;
		end
	end

	insn_known: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid |-> !$isunknown(insn))
		else $error("instruction word has unknown bits");

endmodule

`default_nettype wire

//--- rtl/core_execute.sv
`timescale 1ns/100ps
`default_nettype none

module core_execute
	import core_isa_pkg::*, core_uarch_pkg::*;
(
	input  logic         d_valid,
	input  logic         d_undefined,
	input  cond_code     d_cond,
	input  dp_opcode     d_op,
	input  logic         d_set_flags,
	input  logic         d_is_imm,
	input  imm8          d_imm,
	input  rot4          d_rot,
	input  shift_type    d_shift,
	input  shift_amt     d_shamt,
	input  reg_num       d_rd,
	input  word          d_rn_val,
	input  word          d_rm_val,
	input  logic         d_branch,
	input  logic         d_link,
	input  branch_offset d_offset,
	input  word          d_pc,

	input  psr_flags     flags,

	output logic         x_executed,
	output logic         x_undefined,
	output logic         x_wb_en,
	output reg_num       x_wb_reg,
	output word          x_wb_data,
	output logic         x_flags_en,
	output psr_flags     x_flags,
	output logic         x_branch,
	output word          x_target
);

	logic fn, fz, fc, fv;
	logic cond_pass, is_compare;
	logic [4:0] rot_amt;
	word imm_ext, imm_rot, ror_val;
	logic [32:0] lsl_ext, lsr_ext, asr_ext;
	word op2, alu_res;
	logic sh_carry;
	word add_x, add_y;
	logic add_cin, arith, add_ovf;
	logic [32:0] add_sum;

	assign fn = flags[FLAG_N];
	assign fz = flags[FLAG_Z];
	assign fc = flags[FLAG_C];
	assign fv = flags[FLAG_V];

	always_comb begin
		case (d_cond)
			COND_EQ: cond_pass = fz;
			COND_NE: cond_pass = !fz;
			COND_CS: cond_pass = fc;
			COND_CC: cond_pass = !fc;
			COND_MI: cond_pass = fn;
			COND_PL: cond_pass = !fn;
			COND_VS: cond_pass = fv;
			COND_VC: cond_pass = !fv;
			COND_HI: cond_pass = fc && !fz;
			COND_LS: cond_pass = !fc || fz;
			COND_GE: cond_pass = fn == fv;
			COND_LT: cond_pass = fn != fv;
			COND_GT: cond_pass = !fz && fn == fv;
			COND_LE: cond_pass = fz || fn != fv;
			COND_AL: cond_pass = 1'b1;
			default: cond_pass = 1'b0; // NV
		endcase
	end

	assign rot_amt = {d_rot, 1'b0};
	assign imm_ext = {24'd0, d_imm};
	assign imm_rot = (imm_ext >> rot_amt) | (imm_ext << (6'd32 - rot_amt));
	assign ror_val = (d_rm_val >> d_shamt) | (d_rm_val << (6'd32 - d_shamt));

	// Carry rides along in the extra bit
	assign lsl_ext = {fc, d_rm_val} << d_shamt;
	assign lsr_ext = {d_rm_val, 1'b0} >> d_shamt;
	assign asr_ext = $signed({d_rm_val, 1'b0}) >>> d_shamt;

	always_comb begin
		if (d_is_imm) begin
			op2 = imm_rot;
			sh_carry = (d_rot == '0) ? fc : imm_rot[31];
		end else begin
			case (d_shift)
				SHIFT_LSL: {sh_carry, op2} = lsl_ext;
				SHIFT_LSR:
					if (d_shamt == '0) {op2, sh_carry} = {32'd0, d_rm_val[31]}; // LSR #32
					else {op2, sh_carry} = lsr_ext;
				SHIFT_ASR:
					if (d_shamt == '0) {op2, sh_carry} = {{32{d_rm_val[31]}}, d_rm_val[31]};
					else {op2, sh_carry} = asr_ext;
				default:
					if (d_shamt == '0) {op2, sh_carry} = {fc, d_rm_val}; // RRX
					else {op2, sh_carry} = {ror_val, ror_val[31]};
			endcase
		end
	end

	always_comb begin
		add_x = d_rn_val;
		add_y = op2;
		add_cin = 1'b0;
		arith = 1'b0;
		alu_res = op2;
		case (d_op)
			OP_AND, OP_TST: alu_res = d_rn_val & op2;
			OP_EOR, OP_TEQ: alu_res = d_rn_val ^ op2;
			OP_SUB, OP_CMP: begin
				add_y = ~op2;
				add_cin = 1'b1;
				arith = 1'b1;
			end
			OP_RSB: begin
				add_x = ~d_rn_val;
				add_cin = 1'b1;
				arith = 1'b1;
			end
			OP_ADD, OP_CMN: arith = 1'b1;
			OP_ADC: begin
				add_cin = fc;
				arith = 1'b1;
			end
			OP_SBC: begin
				add_y = ~op2;
				add_cin = fc;
				arith = 1'b1;
			end
			OP_RSC: begin
				add_x = ~d_rn_val;
				add_cin = fc;
				arith = 1'b1;
			end
			OP_ORR: alu_res = d_rn_val | op2;
			OP_BIC: alu_res = d_rn_val & ~op2;
			OP_MVN: alu_res = ~op2;
			default: alu_res = op2; // MOV
		endcase
		add_sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};
		if (arith)
			alu_res = add_sum[31:0];
	end

	assign add_ovf = add_x[31] == add_y[31] && add_sum[31] != add_x[31];
	assign is_compare = d_op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};

	assign x_executed = d_valid && !d_undefined && cond_pass;
	assign x_undefined = d_valid && d_undefined;

	assign x_wb_en = x_executed && (d_branch ? d_link : !is_compare);
	assign x_wb_reg = d_branch ? REG_LR : d_rd;
	assign x_wb_data = d_branch ? d_pc + LINK_AHEAD : alu_res;

	assign x_flags_en = x_executed && !d_branch && d_set_flags;
	assign x_flags = {alu_res[31], alu_res == '0,
		arith ? add_sum[32] : sh_carry, arith ? add_ovf : fv};

	assign x_branch = x_executed && d_branch;
	assign x_target = d_pc + PC_AHEAD + {{6{d_offset[23]}}, d_offset, 2'b00};

	// Destination r15 must have been decoded as undefined
	always_comb begin
		wb_not_pc: assert (!(x_wb_en && x_wb_reg == REG_PC))
			else $error("write port aimed at r15");
	end

endmodule

`default_nettype wire

//--- rtl/core_isa_pkg.sv
`default_nettype none

package core_isa_pkg;

	typedef logic [31:0] insn_word;

	typedef enum logic [3:0] {
		COND_EQ, COND_NE, COND_CS, COND_CC,
		COND_MI, COND_PL, COND_VS, COND_VC,
		COND_HI, COND_LS, COND_GE, COND_LT,
		COND_GT, COND_LE, COND_AL, COND_NV
	} cond_code;

	// Bits 24:21 of a data-processing instruction
	typedef enum logic [3:0] {
		OP_AND, OP_EOR, OP_SUB, OP_RSB,
		OP_ADD, OP_ADC, OP_SBC, OP_RSC,
		OP_TST, OP_TEQ, OP_CMP, OP_CMN,
		OP_ORR, OP_MOV, OP_BIC, OP_MVN
	} dp_opcode;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR // ROR #0 encodes RRX
	} shift_type;

	// Operand two, immediate form
	typedef logic [7:0] imm8;
	typedef logic [3:0] rot4; // Rotate right by twice this

	// Operand two, register form
	typedef logic [4:0] shift_amt;

	// Signed word offset, bits 23:0 of B and BL
	typedef logic [23:0] branch_offset;

endpackage

`default_nettype wire

//--- rtl/core_result.sv
`timescale 1ns/100ps
`default_nettype none

module core_result
	import core_uarch_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,

	input  logic     d_valid,
	input  logic     x_executed,
	input  logic     x_undefined,
	input  logic     x_wb_en,
	input  reg_num   x_wb_reg,
	input  word      x_wb_data,
	input  logic     x_flags_en,
	input  psr_flags x_flags,
	input  logic     x_branch,
	input  word      x_target,

	input  reg_num   rn_addr,
	input  reg_num   rm_addr,
	output word      rn_rdata,
	output word      rm_rdata,
	output psr_flags flags,

	output logic     retire,
	output logic     retire_executed,
	output logic     retire_undefined,
	output logic     wb_en,
	output reg_num   wb_reg,
	output word      wb_data,
	output logic     branch_taken,
	output word      branch_target
);

	word regs [16]; // r15 is never written, reads of it come from the pc

	assign rn_rdata = regs[rn_addr];
	assign rm_rdata = regs[rm_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
			flags <= '0;
		end else begin
			if (d_valid && x_wb_en)
				regs[x_wb_reg] <= x_wb_data;
			if (d_valid && x_flags_en)
				flags <= x_flags;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire <= 1'b0;
			retire_executed <= 1'b0;
			retire_undefined <= 1'b0;
			wb_en <= 1'b0;
			branch_taken <= 1'b0;
		end else begin
			retire <= d_valid;
			retire_executed <= x_executed;
			retire_undefined <= x_undefined;
			wb_en <= d_valid && x_wb_en;
			branch_taken <= x_branch;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg <= x_wb_reg;
		wb_data <= x_wb_data;
		branch_target <= x_target;
	end

	wb_needs_exec: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> retire && retire_executed)
		else $error("write-back reported without an executed retire");

endmodule

`default_nettype wire

//--- rtl/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top
	import core_isa_pkg::*, core_uarch_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,

	input  logic     insn_valid,
	input  insn_word insn,
	input  word      insn_pc,

	output logic     retire,
	output logic     retire_executed,
	output logic     retire_undefined,
	output logic     wb_en,
	output reg_num   wb_reg,
	output word      wb_data,
	output logic     branch_taken,
	output word      branch_target,
	output psr_flags flags
);

	reg_num rn_addr, rm_addr;
	word rn_rdata, rm_rdata;

	logic d_valid, d_undefined, d_set_flags, d_is_imm, d_branch, d_link;
	cond_code d_cond;
	dp_opcode d_op;
	imm8 d_imm;
	rot4 d_rot;
	shift_type d_shift;
	shift_amt d_shamt;
	reg_num d_rd;
	word d_rn_val, d_rm_val, d_pc;
	branch_offset d_offset;

	logic x_executed, x_undefined, x_wb_en, x_flags_en, x_branch;
	reg_num x_wb_reg;
	word x_wb_data, x_target;
	psr_flags x_flags;

	core_decode u_decode (
		.clk, .arst_n, .insn_valid, .insn, .insn_pc,
		.rn_addr, .rm_addr, .rn_rdata, .rm_rdata,
		.wb_en(x_wb_en), .wb_reg(x_wb_reg), .wb_data(x_wb_data), // Bypass
		.d_valid, .d_undefined, .d_cond, .d_op, .d_set_flags,
		.d_is_imm, .d_imm, .d_rot, .d_shift, .d_shamt, .d_rd,
		.d_rn_val, .d_rm_val, .d_branch, .d_link, .d_offset, .d_pc
	);

	core_execute u_execute (
		.d_valid, .d_undefined, .d_cond, .d_op, .d_set_flags,
		.d_is_imm, .d_imm, .d_rot, .d_shift, .d_shamt, .d_rd,
		.d_rn_val, .d_rm_val, .d_branch, .d_link, .d_offset, .d_pc,
		.flags,
		.x_executed, .x_undefined, .x_wb_en, .x_wb_reg, .x_wb_data,
		.x_flags_en, .x_flags, .x_branch, .x_target
	);

	core_result u_result (
		.clk, .arst_n, .d_valid,
		.x_executed, .x_undefined, .x_wb_en, .x_wb_reg, .x_wb_data,
		.x_flags_en, .x_flags, .x_branch, .x_target,
		.rn_addr, .rm_addr, .rn_rdata, .rm_rdata, .flags,
		.retire, .retire_executed, .retire_undefined,
		.wb_en, .wb_reg, .wb_data, .branch_taken, .branch_target
	);

endmodule

`default_nettype wire

//--- rtl/core_uarch_pkg.sv
`default_nettype none

package core_uarch_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	// N Z C V, most significant first
	typedef logic [3:0] psr_flags;

	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	localparam reg_num REG_LR = 4'd14;
	localparam reg_num REG_PC = 4'd15;

	// r15 reads as two instructions ahead
	localparam word PC_AHEAD = 32'd8;
	localparam word LINK_AHEAD = 32'd4;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f list.f --top-module core_tb -o core_sim &&
	./obj_dir/core_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
	echo "run.sh: PASS" ||
	{ echo "run.sh: FAIL"; exit 1; }

//--- tests/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb
	import core_isa_pkg::*, core_uarch_pkg::*;
();

	typedef struct packed {
		logic     executed;
		logic     undefined;
		logic     wb_en;
		reg_num   wb_reg;
		word      wb_data;
		logic     branch;
		word      target;
		psr_flags flags;
	} retire_rec;

	logic clk, arst_n;
	logic insn_valid;
	insn_word insn;
	word insn_pc;

	logic retire, retire_executed, retire_undefined, wb_en, branch_taken;
	reg_num wb_reg;
	word wb_data, branch_target;
	psr_flags flags;

	integer seed = 32'hbd8f;
	int n_checks = 0;
	int n_mismatch = 0;
	int n_other = 0;
	retire_rec exp_q[$];
	word model_regs [16];
	psr_flags model_flags;
	word pc;

	core_tb_clock u_clock (.clk, .arst_n);

	core_top u_dut (
		.clk, .arst_n, .insn_valid, .insn, .insn_pc,
		.retire, .retire_executed, .retire_undefined,
		.wb_en, .wb_reg, .wb_data, .branch_taken, .branch_target, .flags
	);

	task automatic check_bit(input string name, input logic got, input logic want);
		n_checks++;
		if (got !== want) begin
			n_mismatch++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_reg(input string name, input reg_num got, input reg_num want);
		n_checks++;
		if (got !== want) begin
			n_mismatch++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_word(input string name, input word got, input word want);
		n_checks++;
		if (got !== want) begin
			n_mismatch++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flags(input string name, input psr_flags got, input psr_flags want);
		n_checks++;
		if (got !== want) begin
			n_mismatch++;
			$display("FAILED %s: got %h, expected %h", name, got, want);
		end
	endtask

	function automatic word next_rand();
		return $random(seed);
	endfunction

	function automatic reg_num rand_reg();
		word r;
		r = next_rand();
		return {1'b0, r[2:0]}; // r0 to r7
	endfunction

	function automatic insn_word dp_imm_insn(input cond_code cc, input dp_opcode op,
		input logic s, input reg_num rn, input reg_num rd, input rot4 rot, input imm8 imm);
		return {cc, 3'b001, op, s, rn, rd, rot, imm};
	endfunction

	function automatic insn_word dp_reg_insn(input cond_code cc, input dp_opcode op,
		input logic s, input reg_num rn, input reg_num rd, input shift_amt amt,
		input shift_type sh, input reg_num rm);
		return {cc, 3'b000, op, s, rn, rd, amt, sh, 1'b0, rm};
	endfunction

	function automatic insn_word branch_insn(input cond_code cc, input logic link,
		input branch_offset off);
		return {cc, 3'b101, link, off};
	endfunction

	function automatic word ror32(input word v, input int amt);
		return (amt == 0) ? v : (v >> amt) | (v << (32 - amt));
	endfunction

	// Packs result, carry and overflow
	function automatic logic [33:0] add_op(input word a, input word b, input logic cin);
		logic [32:0] u;
		longint s;
		u = {1'b0, a} + {1'b0, b} + {32'd0, cin};
		s = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
		return {u[31:0], u[32], s != longint'($signed(u[31:0]))};
	endfunction

	// Carry out is the inverse of the borrow
	function automatic logic [33:0] sub_op(input word a, input word b, input logic borrow);
		logic [32:0] u;
		longint s;
		u = {1'b0, a} - {1'b0, b} - {32'd0, borrow};
		s = longint'($signed(a)) - longint'($signed(b)) - longint'(borrow);
		return {u[31:0], !u[32], s != longint'($signed(u[31:0]))};
	endfunction

	function automatic logic cond_holds(input cond_code cc, input psr_flags f);
		logic n, z, c, v;
		{n, z, c, v} = f;
		case (cc)
			COND_EQ: return z;
			COND_NE: return !z;
			COND_CS: return c;
			COND_CC: return !c;
			COND_MI: return n;
			COND_PL: return !n;
			COND_VS: return v;
			COND_VC: return !v;
			COND_HI: return c && !z;
			COND_LS: return !c || z;
			COND_GE: return n == v;
			COND_LT: return n != v;
			COND_GT: return !z && n == v;
			COND_LE: return z || n != v;
			COND_AL: return 1'b1;
			default: return 1'b0; // NV never runs
		endcase
	endfunction

	function automatic word model_read(input reg_num r, input word at);
		return (r == 4'd15) ? at + 8 : model_regs[r];
	endfunction

	// Reference model that runs in program order
	task automatic model_step(input insn_word i, input word at, output retire_rec r);
		dp_opcode op;
		logic n, z, c, v;
		logic sh_c, arith, is_cmp, undef;
		logic [33:0] ar;
		word a, b, rmv, res;
		int amt;
		{n, z, c, v} = model_flags;
		op = dp_opcode'(i[24:21]);
		is_cmp = op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
		undef = i[27:25] != 3'b101 && (i[27:26] != 2'b00 || (!i[25] && i[4])
			|| (is_cmp && !i[20]) || (i[15:12] == 4'd15 && !is_cmp));
		r = '0;
		r.undefined = undef;
		r.executed = !undef && cond_holds(cond_code'(i[31:28]), model_flags);
		r.flags = model_flags;
		if (i[27:25] == 3'b101) begin
			r.branch = r.executed;
			r.target = at + 8 + word'(4 * int'($signed(i[23:0])));
			r.wb_en = r.executed && i[24];
			r.wb_reg = 4'd14;
			r.wb_data = at + 4;
		end else if (r.executed) begin
			a = model_read(i[19:16], at);
			if (i[25]) begin
				amt = 2 * i[11:8];
				b = ror32({24'd0, i[7:0]}, amt);
				sh_c = (amt == 0) ? c : b[31];
			end else begin
				rmv = model_read(i[3:0], at);
				amt = i[11:7];
				if (amt == 0 && i[6:5] != 2'd0)
					amt = 32; // LSR, ASR #32 and RRX
				case (i[6:5])
					2'd0: begin
						b = rmv << amt;
						sh_c = (amt == 0) ? c : rmv[32 - amt];
					end
					2'd1: begin
						b = rmv >> amt;
						sh_c = rmv[amt - 1];
					end
					2'd2: begin
						b = $signed(rmv) >>> amt;
						sh_c = rmv[amt - 1];
					end
					default: begin
						b = (amt == 32) ? {c, rmv[31:1]} : ror32(rmv, amt);
						sh_c = (amt == 32) ? rmv[0] : b[31];
					end
				endcase
			end
			ar = '0;
			res = '0;
			case (op)
				OP_AND, OP_TST: res = a & b;
				OP_EOR, OP_TEQ: res = a ^ b;
				OP_ORR: res = a | b;
				OP_MOV: res = b;
				OP_BIC: res = a & ~b;
				OP_MVN: res = ~b;
				OP_SUB, OP_CMP: ar = sub_op(a, b, 1'b0);
				OP_RSB: ar = sub_op(b, a, 1'b0);
				OP_SBC: ar = sub_op(a, b, !c);
				OP_RSC: ar = sub_op(b, a, !c);
				OP_ADC: ar = add_op(a, b, c);
				default: ar = add_op(a, b, 1'b0); // ADD and CMN
			endcase
			arith = op inside {OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC, OP_CMP, OP_CMN};
			if (arith) begin
				res = ar[33:2];
				sh_c = ar[1];
				v = ar[0];
			end
			r.wb_en = !is_cmp;
			r.wb_reg = i[15:12];
			r.wb_data = res;
			if (i[20])
				r.flags = {res[31], res == '0, sh_c, v};
		end
		if (r.wb_en)
			model_regs[r.wb_reg] = r.wb_data;
		model_flags = r.flags;
	endtask

	task automatic issue_insn(input insn_word i);
		retire_rec r;
		@(posedge clk);
		insn_valid <= 1'b1;
		insn <= i;
		insn_pc <= pc;
		model_step(i, pc, r);
		exp_q.push_back(r);
		pc = pc + 4;
	endtask

	// Ends the burst, then waits until everything issued has retired
	task automatic expect_retire();
		int cycles;
		@(posedge clk);
		insn_valid <= 1'b0;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 16) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			n_other++;
			$display("Timed out with %0d instructions not retired", exp_q.size());
			exp_q.delete();
		end
	endtask

	always @(negedge clk) begin
		retire_rec e;
		if (arst_n && retire) begin
			if (exp_q.size() == 0) begin
				n_other++;
				$display("Retire seen with no instruction in flight");
			end else begin
				e = exp_q.pop_front();
				check_bit("retire_executed", retire_executed, e.executed);
				check_bit("retire_undefined", retire_undefined, e.undefined);
				check_bit("wb_en", wb_en, e.wb_en);
				check_bit("branch_taken", branch_taken, e.branch);
				if (e.wb_en) begin
					check_reg("wb_reg", wb_reg, e.wb_reg);
					check_word("wb_data", wb_data, e.wb_data);
				end
				if (e.branch)
					check_word("branch_target", branch_target, e.target);
				check_flags("flags", flags, e.flags);
			end
		end
	end

	task automatic load_immediates();
		word r;
		for (int k = 0; k < 8; k++) begin
			r = next_rand();
			issue_insn(dp_imm_insn(COND_AL, OP_MOV, 1'b0, 4'd0, reg_num'(k), r[11:8], r[7:0]));
			expect_retire();
		end
	endtask

	task automatic exercise_dp_ops();
		word r;
		dp_opcode op;
		shift_type st;
		logic cmp;
		for (int k = 0; k < 16; k++) begin
			op = dp_opcode'(k);
			cmp = op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
			for (int sh = 0; sh < 5; sh++) begin
				r = next_rand();
				st = (sh == 4) ? SHIFT_ROR : shift_type'(sh);
				issue_insn(dp_reg_insn(COND_AL, op, r[0] | cmp, rand_reg(),
					cmp ? 4'd0 : rand_reg(), (sh == 4) ? 5'd0 : r[12:8], st, rand_reg()));
			end
			r = next_rand();
			issue_insn(dp_imm_insn(COND_AL, op, r[0] | cmp, rand_reg(),
				cmp ? 4'd0 : rand_reg(), r[11:8], r[19:12]));
			expect_retire();
		end
	endtask

	task automatic chain_dependent();
		word r;
		reg_num prev_rd, rd, rm;
		prev_rd = 4'd0;
		for (int k = 0; k < 12; k++) begin
			r = next_rand();
			rd = {2'b00, r[5:4]};
			rm = r[15] ? prev_rd : {2'b00, r[14:13]};
			issue_insn(dp_reg_insn(COND_AL, r[0] ? OP_ADD : OP_EOR, r[1], prev_rd, rd,
				r[10:6], shift_type'(r[12:11]), rm));
			prev_rd = rd;
		end
		expect_retire();
	endtask

	task automatic walk_conditions();
		word r;
		for (int k = 0; k < 16; k++) begin
			for (int round = 0; round < 2; round++) begin
				r = next_rand();
				if (round == 0)
					issue_insn(dp_reg_insn(COND_AL, OP_CMP, 1'b1, 4'd1, 4'd0, 5'd0,
						SHIFT_LSL, 4'd1));
				else
					issue_insn(dp_reg_insn(COND_AL, OP_CMP, 1'b1, rand_reg(), 4'd0, 5'd0,
						SHIFT_LSL, rand_reg()));
				issue_insn(dp_imm_insn(cond_code'(k), OP_MOV, 1'b0, 4'd0, 4'd5, 4'd0, r[7:0]));
				// A skipped write shows in the r5 read back
				issue_insn(dp_reg_insn(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd6, 5'd0, SHIFT_LSL, 4'd5));
				expect_retire();
			end
		end
	endtask

	task automatic take_branches();
		word r;
		pc = 32'h0000_8000;
		r = next_rand();
		issue_insn(branch_insn(COND_AL, 1'b0, r[23:0]));
		issue_insn(branch_insn(COND_AL, 1'b0, 24'hfffff0)); // Backwards
		issue_insn(branch_insn(COND_AL, 1'b1, r[31:8]));
		issue_insn(dp_reg_insn(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd7, 5'd0, SHIFT_LSL, 4'd14));
		issue_insn(dp_reg_insn(COND_AL, OP_CMP, 1'b1, 4'd0, 4'd0, 5'd0, SHIFT_LSL, 4'd0));
		issue_insn(branch_insn(COND_NE, 1'b1, r[23:0]));
		issue_insn(dp_reg_insn(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd8, 5'd0, SHIFT_LSL, 4'd14));
		issue_insn(branch_insn(COND_EQ, 1'b1, 24'h800000));
		issue_insn(dp_imm_insn(COND_AL, OP_ADD, 1'b0, 4'd15, 4'd9, 4'd0, 8'd4)); // Reads r15
		expect_retire();
	endtask

	task automatic reject_undefined();
		// MULS, LDR, MCR, ADDS by register, MOVS to pc, MRS
		insn_word bad [6] = '{32'he0110392, 32'he5912000, 32'hee010f10,
			32'he0921413, 32'he1b0f000, 32'he10f0000};
		foreach (bad[k])
			issue_insn(bad[k]);
		for (int k = 0; k < 15; k++)
			issue_insn(dp_reg_insn(COND_AL, OP_MOV, 1'b0, 4'd0, 4'd8, 5'd0, SHIFT_LSL,
				reg_num'(k)));
		expect_retire();
	endtask

	initial begin
		int cycles;
		insn_valid = 1'b0;
		insn = '0;
		insn_pc = '0;
		for (int k = 0; k < 16; k++)
			model_regs[k] = '0;
		model_flags = '0;
		pc = 32'h0000_0100;
		cycles = 0;
		while (arst_n !== 1'b1 && cycles < 32) begin
			@(posedge clk);
			cycles++;
		end
		if (arst_n !== 1'b1) begin
			n_other++;
			$display("Reset was never released");
		end
		@(negedge clk);
		check_bit("retire", retire, 1'b0);
		check_bit("wb_en", wb_en, 1'b0);
		check_bit("branch_taken", branch_taken, 1'b0);
		check_flags("flags", flags, '0);

		load_immediates();
		exercise_dp_ops();
		chain_dependent();
		walk_conditions();
		take_branches();
		reject_undefined();

		$display("Checks %0d, value mismatches %0d, other errors %0d",
			n_checks, n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/core_tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb_clock (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1; // Released between edges
	end

endmodule

`default_nettype wire
